//--- hw/bt_defs.svh
`ifndef BT_DEFS_SVH
`define BT_DEFS_SVH

// ========================================
// Clock ratios, MHz units
// ========================================

// System clock into the enable generators
`define BT_SYS_HZ_NUM 64
// Video pixel clock doubled, 10 MHz x2
`define BT_VID_X2_NUM 20
// Sound chip clock doubled, 6 MHz x2
`define BT_SND_X2_NUM 12

// ========================================
// Loader indices
// ========================================

`define BT_IDX_W 6
`define BT_IDX_ROM0 6'd0
`define BT_IDX_ROM1 6'd1
`define BT_IDX_SROM 6'd2

// Nonzero: sound ROM must arrive before the core leaves reset
`define BT_SOUND_EN 1

// ========================================
// Game memory map
// ========================================

// Seven-bit prefixes above the 21-bit region offset
`define BT_BASE_RAM 7'd4
`define BT_BASE_NVRAM 7'd8
`define BT_BASE_SPR 7'd12
`define BT_ROM_OFS_W 23
`define BT_REG_OFS_W 21

`endif

//--- hw/bt_pkg.sv
`default_nettype none

`include "bt_defs.svh"

package bt_pkg;

	// ========================================
	// Region select
	// ========================================

	// Top bit is the valid flag, low two bits the region code
	typedef enum logic [2:0] {
		region_none  = 3'b000,
		region_ram   = 3'b100,
		region_nvram = 3'b101,
		region_spr   = 3'b110,
		region_rom   = 3'b111
	} region_t;

	// ========================================
	// Address and data
	// ========================================

	// DDR word address, byte address bit 0 dropped
	typedef logic [26:0] ddr_word_addr_t;

	// Core address, ROM offset is the widest
	typedef logic [`BT_ROM_OFS_W-1:0] game_addr_t;

	typedef logic [31:0] word32_t;

	// Loader byte address and 16-bit payload
	typedef logic [24:0] load_addr_t;
	typedef logic [15:0] load_data_t;

endpackage

`default_nettype wire

//--- hw/fractional_ce.sv
`timescale 1ns/1ps
`default_nettype none

module fractional_ce #(
	parameter int IN_RATE = 64,
	parameter int OUT_RATE = 20
) (
	input  logic clk_sys,
	input  logic reset,
	output logic ce
);

	// Room for the sum before it is wrapped back
	localparam int ACC_W = $clog2(IN_RATE + OUT_RATE) + 1;

	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] sum;

	// Next accumulator value before wrap
	assign sum = acc + ACC_W'(OUT_RATE);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			acc <= '0;
			ce <= 1'b0;
		end else if (sum >= ACC_W'(IN_RATE)) begin
			// Wrap and emit one enable
			acc <= sum - ACC_W'(IN_RATE);
			ce <= 1'b1;
		end else begin
			acc <= sum;
			ce <= 1'b0;
		end
	end

	// Below half rate an enable is always followed by a gap
	if (2 * OUT_RATE < IN_RATE) begin : g_gap_chk
		a_ce_gap: assert property (@(posedge clk_sys) disable iff (reset)
			ce |=> !ce)
			else $error("fractional_ce: enable held for two cycles");
	end

endmodule

`default_nettype wire

//--- hw/clock_enables.sv
`timescale 1ns/1ps
`default_nettype none

`include "bt_defs.svh"

module clock_enables (
	input  logic clk_sys,
	input  logic reset,
	output logic cpu_ce_f,
	output logic cpu_ce_r,
	output logic vid_ce_r,
	output logic snd_ce_f,
	output logic snd_ce_r
);

	// Doubled-rate strobes from the generators
	logic vid_x2;
	logic snd_x2;

	// Divide-by-two phase toggles
	logic vid_div;
	logic snd_div;

	// ========================================
	// CPU half-rate pair
	// ========================================

	// Fall enable toggles, rise enable trails by one cycle
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_ce_f <= 1'b0;
			cpu_ce_r <= 1'b0;
		end else begin
			cpu_ce_f <= ~cpu_ce_f;
			cpu_ce_r <= cpu_ce_f;
		end
	end

	// ========================================
	// Video and sound enables
	// ========================================

	fractional_ce #(
		.IN_RATE(`BT_SYS_HZ_NUM),
		.OUT_RATE(`BT_VID_X2_NUM)
	) u_vid_ce (
		.clk_sys(clk_sys),
		.reset(reset),
		.ce(vid_x2)
	);

	fractional_ce #(
		.IN_RATE(`BT_SYS_HZ_NUM),
		.OUT_RATE(`BT_SND_X2_NUM)
	) u_snd_ce (
		.clk_sys(clk_sys),
		.reset(reset),
		.ce(snd_x2)
	);

	// Phase toggles advance only on their own strobe
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vid_div <= 1'b0;
			snd_div <= 1'b0;
		end else begin
			if (vid_x2)
				vid_div <= ~vid_div;
			if (snd_x2)
				snd_div <= ~snd_div;
		end
	end

	// Every second video strobe
	assign vid_ce_r = vid_x2 & vid_div;

	// Sound strobes split across the two phases
	assign snd_ce_f = snd_x2 & ~snd_div;
	assign snd_ce_r = snd_x2 & snd_div;

	a_snd_phase: assert property (@(posedge clk_sys) disable iff (reset)
		!(snd_ce_f && snd_ce_r))
		else $error("clock_enables: sound enables overlap");

endmodule

`default_nettype wire

//--- hw/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "bt_defs.svh"

module rom_loader (
	input  logic clk_sys,
	input  logic reset,
	input  logic reset_request,
	input  logic load_active,
	input  logic [`BT_IDX_W-1:0] load_index,
	input  bt_pkg::load_addr_t load_addr,
	input  bt_pkg::load_data_t load_data,
	input  logic load_wr,
	input  logic ddr_io_busy,
	input  logic sdr_busy,
	input  logic [20:0] snd_addr,
	input  logic snd_rd,
	output logic load_wait,
	output logic core_reset,
	output logic loading,
	output bt_pkg::ddr_word_addr_t ddr_io_addr,
	output bt_pkg::word32_t ddr_io_din,
	output logic [3:0] ddr_io_we,
	output bt_pkg::load_addr_t sdr_addr,
	output bt_pkg::load_data_t sdr_din,
	output logic sdr_wr,
	output logic sdr_rd,
	output logic sdr_word
);

	// Sound image counts as loaded when sound is left out
	localparam logic [2:0] DONE_INIT = (`BT_SOUND_EN != 0) ? 3'b000 : 3'b100;

	// Per-image download flags, bit 2 sound, bit 1 ROM1, bit 0 ROM0
	logic [2:0] dl;
	logic [2:0] dl_q;
	logic [2:0] load_done;

	// Busy history for falling-edge detect
	logic ddr_io_busy_q;
	logic sdr_busy_q;
	logic ddr_io_fall;
	logic sdr_fall;

	// Which memory the pending write went to
	logic wait_on_sdr;

	// ========================================
	// Index decode
	// ========================================

	assign dl[0] = load_active && (load_index == `BT_IDX_ROM0);
	assign dl[1] = load_active && (load_index == `BT_IDX_ROM1);
	assign dl[2] = load_active && (load_index == `BT_IDX_SROM);

	assign loading = |dl;

	assign ddr_io_fall = ddr_io_busy_q & ~ddr_io_busy;
	assign sdr_fall = sdr_busy_q & ~sdr_busy;

	// ========================================
	// Loader stall
	// ========================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ddr_io_busy_q <= 1'b0;
			sdr_busy_q <= 1'b0;
			load_wait <= 1'b0;
			wait_on_sdr <= 1'b0;
		end else begin
			ddr_io_busy_q <= ddr_io_busy;
			sdr_busy_q <= sdr_busy;
			if (load_wr && loading) begin
				// Hold the loader until the target finishes
				load_wait <= 1'b1;
				wait_on_sdr <= dl[2];
			end else if (wait_on_sdr ? sdr_fall : ddr_io_fall) begin
				load_wait <= 1'b0;
			end
		end
	end

	// ========================================
	// Completion and core reset
	// ========================================

	// A done bit sets when its download drops
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_q <= 3'b000;
			load_done <= DONE_INIT;
		end else begin
			dl_q <= dl;
			load_done <= load_done | (dl_q & ~dl);
		end
	end

	assign core_reset = reset | reset_request | ~&load_done;

	// ========================================
	// DDR load port
	// ========================================

	// Word-aligned, payload copied to both halves
	assign ddr_io_addr = {2'b00, load_addr[24:1], 1'b0};
	assign ddr_io_din = {2{load_data}};
	// ROM1 takes the upper lanes, ROM0 the lower
	assign ddr_io_we = {{2{dl[1] & load_wr}}, {2{dl[0] & load_wr}}};

	// ========================================
	// SDRAM port mux
	// ========================================

	// Loader owns the port during the sound download
	assign sdr_addr = dl[2] ? load_addr : {4'b0000, snd_addr};
	assign sdr_din = dl[2] ? load_data : '0;
	assign sdr_wr = dl[2] & load_wr;
	assign sdr_rd = ~dl[2] & snd_rd;
	assign sdr_word = dl[2];

	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		load_wait |-> !load_wr)
		else $error("rom_loader: loader strobed while stalled");

endmodule

`default_nettype wire

//--- hw/game_memory_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "bt_defs.svh"

module game_memory_map (
	input  bt_pkg::game_addr_t game_addr,
	input  bt_pkg::word32_t game_wdata,
	input  logic [3:0] game_be,
	input  logic game_rd,
	input  logic sel_ram,
	input  logic sel_nvram,
	input  logic sel_spr,
	input  logic sel_rom,
	input  logic ddr_busy,
	input  bt_pkg::word32_t ddr_rdata,
	output bt_pkg::ddr_word_addr_t ddr_addr,
	output bt_pkg::word32_t ddr_din,
	output bt_pkg::word32_t game_rdata,
	output logic [3:0] ddr_we,
	output logic ddr_rd,
	output logic [1:0] ddr_cache,
	output logic game_ready
);

	// Byte address is one bit wider than the word address
	localparam int BYTE_W = $bits(bt_pkg::ddr_word_addr_t) + 1;

	bt_pkg::region_t region;
	logic [BYTE_W-1:0] byte_addr;
	logic writable;

	// ========================================
	// Select priority
	// ========================================

	always_comb begin
		if (sel_ram)
			region = bt_pkg::region_ram;
		else if (sel_nvram)
			region = bt_pkg::region_nvram;
		else if (sel_spr)
			region = bt_pkg::region_spr;
		else if (sel_rom)
			region = bt_pkg::region_rom;
		else
			region = bt_pkg::region_none;
	end

	// ========================================
	// Address formation
	// ========================================

	always_comb begin
		case (region)
			bt_pkg::region_ram:
				byte_addr = {`BT_BASE_RAM, game_addr[`BT_REG_OFS_W-1:0]};
			bt_pkg::region_nvram:
				byte_addr = {`BT_BASE_NVRAM, game_addr[`BT_REG_OFS_W-1:0]};
			bt_pkg::region_spr:
				byte_addr = {`BT_BASE_SPR, game_addr[`BT_REG_OFS_W-1:0]};
			// ROM sits at the bottom of DDR
			bt_pkg::region_rom:
				byte_addr = {{(BYTE_W - `BT_ROM_OFS_W){1'b0}}, game_addr};
			default:
				byte_addr = '0;
		endcase
	end

	assign ddr_addr = byte_addr[BYTE_W-1:1];
	// Cache line set picked by the region prefix bits
	assign ddr_cache = byte_addr[24:23];

	// ========================================
	// Enables and reply
	// ========================================

	// ROM is read-only
	assign writable = region[2] && (region != bt_pkg::region_rom);

	assign ddr_din = game_wdata;
	assign ddr_we = game_be & {4{writable}};
	assign ddr_rd = game_rd & region[2];
	assign game_rdata = ddr_rdata;

	// Idle bus reports ready
	assign game_ready = region[2] ? ~ddr_busy : 1'b1;

	// Core must never assert two regions at once
	always_comb begin
		a_sel_onehot: assert #0 ($onehot0({sel_ram, sel_nvram, sel_spr, sel_rom}))
			else $error("game_memory_map: overlapping region selects");
	end

endmodule

`default_nettype wire

//--- hw/bt_core_support.sv
`timescale 1ns/1ps
`default_nettype none

`include "bt_defs.svh"

module bt_core_support (
	input  logic clk_sys,
	input  logic reset,
	input  logic reset_request,
	// Enables
	output logic cpu_ce_f,
	output logic cpu_ce_r,
	output logic vid_ce_r,
	output logic snd_ce_f,
	output logic snd_ce_r,
	// Loader
	input  logic load_active,
	input  logic [`BT_IDX_W-1:0] load_index,
	input  bt_pkg::load_addr_t load_addr,
	input  bt_pkg::load_data_t load_data,
	input  logic load_wr,
	output logic load_wait,
	output logic core_reset,
	output logic loading,
	// DDR load port
	output bt_pkg::ddr_word_addr_t ddr_io_addr,
	output bt_pkg::word32_t ddr_io_din,
	output logic [3:0] ddr_io_we,
	input  logic ddr_io_busy,
	// Game core
	input  bt_pkg::game_addr_t game_addr,
	input  bt_pkg::word32_t game_wdata,
	input  logic [3:0] game_be,
	input  logic game_rd,
	input  logic sel_ram,
	input  logic sel_nvram,
	input  logic sel_spr,
	input  logic sel_rom,
	output bt_pkg::word32_t game_rdata,
	output logic game_ready,
	// DDR game port
	output bt_pkg::ddr_word_addr_t ddr_addr,
	output bt_pkg::word32_t ddr_din,
	output logic [3:0] ddr_we,
	output logic ddr_rd,
	output logic [1:0] ddr_cache,
	input  logic ddr_busy,
	input  bt_pkg::word32_t ddr_rdata,
	// Sound chip and SDRAM
	input  logic [20:0] snd_addr,
	input  logic snd_rd,
	output bt_pkg::load_addr_t sdr_addr,
	output bt_pkg::load_data_t sdr_din,
	output logic sdr_wr,
	output logic sdr_rd,
	output logic sdr_word,
	input  logic sdr_busy
);

	clock_enables u_clock_enables (
		.clk_sys(clk_sys),
		.reset(reset),
		.cpu_ce_f(cpu_ce_f),
		.cpu_ce_r(cpu_ce_r),
		.vid_ce_r(vid_ce_r),
		.snd_ce_f(snd_ce_f),
		.snd_ce_r(snd_ce_r)
	);

	rom_loader u_rom_loader (
		.clk_sys(clk_sys),
		.reset(reset),
		.reset_request(reset_request),
		.load_active(load_active),
		.load_index(load_index),
		.load_addr(load_addr),
		.load_data(load_data),
		.load_wr(load_wr),
		.ddr_io_busy(ddr_io_busy),
		.sdr_busy(sdr_busy),
		.snd_addr(snd_addr),
		.snd_rd(snd_rd),
		.load_wait(load_wait),
		.core_reset(core_reset),
		.loading(loading),
		.ddr_io_addr(ddr_io_addr),
		.ddr_io_din(ddr_io_din),
		.ddr_io_we(ddr_io_we),
		.sdr_addr(sdr_addr),
		.sdr_din(sdr_din),
		.sdr_wr(sdr_wr),
		.sdr_rd(sdr_rd),
		.sdr_word(sdr_word)
	);

	game_memory_map u_game_memory_map (
		.game_addr(game_addr),
		.game_wdata(game_wdata),
		.game_be(game_be),
		.game_rd(game_rd),
		.sel_ram(sel_ram),
		.sel_nvram(sel_nvram),
		.sel_spr(sel_spr),
		.sel_rom(sel_rom),
		.ddr_busy(ddr_busy),
		.ddr_rdata(ddr_rdata),
		.ddr_addr(ddr_addr),
		.ddr_din(ddr_din),
		.game_rdata(game_rdata),
		.ddr_we(ddr_we),
		.ddr_rd(ddr_rd),
		.ddr_cache(ddr_cache),
		.game_ready(game_ready)
	);

endmodule

`default_nettype wire

//--- test/tb_bt_core_support.sv
`timescale 1ns/1ps
`default_nettype none

`include "bt_defs.svh"

module tb_bt_core_support;

	localparam int WIN_CYC = 1600;
	localparam int BUSY_CYC = 3;
	localparam int TIMEOUT = 50;
	localparam int N_WORDS = 4;
	localparam int N_ROWS = 8;

	logic clk_sys = 1'b0;
	logic reset, reset_request, load_active, load_wr, game_rd, snd_rd;
	logic [`BT_IDX_W-1:0] load_index;
	logic [24:0] load_addr;
	logic [15:0] load_data;
	logic [22:0] game_addr;
	logic [31:0] game_wdata, ddr_rdata;
	logic [3:0] game_be;
	logic sel_ram, sel_nvram, sel_spr, sel_rom, ddr_busy;
	logic [20:0] snd_addr;
	// Memory busy models
	logic ddr_io_busy = 1'b0;
	logic sdr_busy = 1'b0;
	int ddr_cnt = 0;
	int sdr_cnt = 0;

	logic cpu_ce_f, cpu_ce_r, vid_ce_r, snd_ce_f, snd_ce_r;
	logic load_wait, core_reset, loading;
	logic [26:0] ddr_io_addr, ddr_addr;
	logic [31:0] ddr_io_din, ddr_din, game_rdata;
	logic [3:0] ddr_io_we, ddr_we;
	logic game_ready, ddr_rd, sdr_wr, sdr_rd, sdr_word;
	logic [1:0] ddr_cache;
	logic [24:0] sdr_addr;
	logic [15:0] sdr_din;

	int n_checks = 0;
	int n_errors = 0;
	int n_timeouts = 0;

	// ========================================
	// Region table
	// ========================================

	// Region code 0 none, 1 ram, 2 nvram, 3 spr, 4 rom
	int tab_region [N_ROWS] = '{0, 1, 1, 2, 2, 3, 4, 4};
	logic [3:0] tab_be [N_ROWS] = '{4'hf, 4'hf, 4'h3, 4'hc, 4'h0, 4'h5, 4'hf, 4'h0};
	logic tab_rd [N_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
	logic tab_busy [N_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
	// Expected prefix, lanes, read and ready
	logic [6:0] tab_prefix [N_ROWS] = '{7'd0, `BT_BASE_RAM, `BT_BASE_RAM, `BT_BASE_NVRAM,
		`BT_BASE_NVRAM, `BT_BASE_SPR, 7'd0, 7'd0};
	logic [3:0] tab_we [N_ROWS] = '{4'h0, 4'hf, 4'h3, 4'hc, 4'h0, 4'h5, 4'h0, 4'h0};
	logic tab_exp_rd [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
	logic tab_ready [N_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};

	bt_core_support uut (.*);

	always #4 clk_sys = ~clk_sys;

	// Few-cycle busy pulse after each write
	always @(posedge clk_sys) begin
		if (ddr_io_we != 4'b0000) begin
			ddr_io_busy <= 1'b1;
			ddr_cnt <= BUSY_CYC;
		end else if (ddr_cnt > 0) begin
			ddr_cnt <= ddr_cnt - 1;
			if (ddr_cnt == 1)
				ddr_io_busy <= 1'b0;
		end
		if (sdr_wr) begin
			sdr_busy <= 1'b1;
			sdr_cnt <= BUSY_CYC;
		end else if (sdr_cnt > 0) begin
			sdr_cnt <= sdr_cnt - 1;
			if (sdr_cnt == 1)
				sdr_busy <= 1'b0;
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		n_checks++;
		assert (act_v === exp_v) else begin
			n_errors++;
			$display("** Error %s: expected %h, actual %h", name, exp_v, act_v);
		end
	endtask

	// One loader write, then wait out the stall
	task automatic load_word(input logic [`BT_IDX_W-1:0] idx, input logic [24:0] addr,
		input logic [15:0] data);
		int n;
		logic is_snd;
		logic [3:0] exp_we;
		is_snd = (idx == `BT_IDX_SROM);
		exp_we = (idx == `BT_IDX_ROM0) ? 4'b0011 :
			(idx == `BT_IDX_ROM1) ? 4'b1100 : 4'b0000;
		@(posedge clk_sys);
		load_addr <= addr;
		load_data <= data;
		load_wr <= 1'b1;
		@(negedge clk_sys);
		check_val("loading", 1, loading);
		check_val("load_wait before strobe edge", 0, load_wait);
		check_val("ddr_io_we lanes", exp_we, ddr_io_we);
		check_val("sdr_wr", is_snd, sdr_wr);
		if (is_snd) begin
			check_val("sdr_addr from loader", addr, sdr_addr);
			check_val("sdr_din", data, sdr_din);
			check_val("sdr_word in download", 1, sdr_word);
			check_val("sdr_rd masked", 0, sdr_rd);
		end else begin
			check_val("ddr_io_din", {data, data}, ddr_io_din);
			check_val("ddr_io_addr", 27'(addr) & ~27'd1, ddr_io_addr);
		end
		@(posedge clk_sys);
		load_wr <= 1'b0;
		@(negedge clk_sys);
		check_val("load_wait rise", 1, load_wait);
		n = 0;
		while (load_wait && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (load_wait) begin
			n_timeouts++;
			$display("Timeout: load_wait stayed high after a write to index %0d", idx);
		end else begin
			check_val("busy low at load_wait fall", 0, is_snd ? sdr_busy : ddr_io_busy);
			// Busy sampled high for BUSY_CYC edges, wait drops on the first low sample
			check_val("load_wait fall cycle", BUSY_CYC + 1, n);
		end
	endtask

	// Whole image with a random base and payload
	task automatic download(input logic [`BT_IDX_W-1:0] idx);
		int k;
		logic [24:0] base;
		base = 25'($urandom) & ~25'd1;
		@(posedge clk_sys);
		load_active <= 1'b1;
		load_index <= idx;
		for (k = 0; k < N_WORDS; k++)
			load_word(idx, base + 25'(2 * k), 16'($urandom));
		@(posedge clk_sys);
		load_active <= 1'b0;
		// Done bit lands one edge after the download drops
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_val("loading after download", 0, loading);
	endtask

	initial begin
		int i, c_cpu, c_vid, c_sf, c_sr, n_overlap, n_pair;
		logic prev_f;
		logic [22:0] ofs;
		logic [27:0] exp_byte;
		logic [20:0] s_addr;
		logic s_rd;
		void'($urandom(59870));
		reset = 1'b1;
		reset_request = 1'b0;
		load_active = 1'b0;
		load_index = '0;
		load_addr = '0;
		load_data = '0;
		load_wr = 1'b0;
		game_addr = '0;
		game_wdata = '0;
		game_be = '0;
		game_rd = 1'b0;
		{sel_ram, sel_nvram, sel_spr, sel_rom} = 4'b0000;
		ddr_busy = 1'b0;
		ddr_rdata = '0;
		snd_addr = '0;
		snd_rd = 1'b0;

		// Enables quiet and core held while in reset
		repeat (4) begin
			@(negedge clk_sys);
			check_val("enables in reset", 0,
				{cpu_ce_f, cpu_ce_r, vid_ce_r, snd_ce_f, snd_ce_r});
			check_val("core_reset in reset", 1, core_reset);
		end
		@(posedge clk_sys);
		reset <= 1'b0;

		// ========================================
		// Enable rates
		// ========================================
		{c_cpu, c_vid, c_sf, c_sr, n_overlap, n_pair} = '0;
		// CPU fall enable leaves reset low
		prev_f = 1'b0;
		@(posedge clk_sys);
		repeat (WIN_CYC) begin
			@(negedge clk_sys);
			// Fall enable toggles, rise enable repeats its last value
			n_pair += (cpu_ce_f == prev_f) || (cpu_ce_r != prev_f);
			prev_f = cpu_ce_f;
			c_cpu += cpu_ce_r;
			c_vid += vid_ce_r;
			c_sf += snd_ce_f;
			c_sr += snd_ce_r;
			n_overlap += (snd_ce_f && snd_ce_r);
		end
		check_val("cpu_ce_f toggle and cpu_ce_r lag mismatches", 0, n_pair);
		check_val("cpu_ce_r count", WIN_CYC / 2, c_cpu);
		check_val("vid_ce_r count", WIN_CYC * `BT_VID_X2_NUM / `BT_SYS_HZ_NUM / 2, c_vid);
		check_val("snd_ce_f count", WIN_CYC * `BT_SND_X2_NUM / `BT_SYS_HZ_NUM / 2, c_sf);
		check_val("snd_ce_r count", WIN_CYC * `BT_SND_X2_NUM / `BT_SYS_HZ_NUM / 2, c_sr);
		check_val("sound enable overlaps", 0, n_overlap);

		// ========================================
		// Downloads and core reset
		// ========================================
		check_val("core_reset before loads", 1, core_reset);
		download(`BT_IDX_ROM0);
		check_val("core_reset after ROM0", 1, core_reset);
		download(`BT_IDX_ROM1);
		check_val("core_reset after ROM1", (`BT_SOUND_EN != 0), core_reset);
		// Sound chip keeps reading while the loader owns the port
		@(posedge clk_sys);
		snd_rd <= 1'b1;
		snd_addr <= 21'($urandom);
		download(`BT_IDX_SROM);
		check_val("core_reset after all loads", 0, core_reset);
		@(posedge clk_sys);
		reset_request <= 1'b1;
		@(negedge clk_sys);
		check_val("core_reset on request", 1, core_reset);
		@(posedge clk_sys);
		reset_request <= 1'b0;
		@(negedge clk_sys);
		check_val("core_reset after request", 0, core_reset);

		// Sound chip owns the SDRAM port again
		for (i = 0; i < 4; i++) begin
			s_addr = 21'($urandom);
			s_rd = 1'($urandom);
			@(posedge clk_sys);
			snd_addr <= s_addr;
			snd_rd <= s_rd;
			@(negedge clk_sys);
			check_val($sformatf("sound %0d sdr_addr", i), {4'b0000, s_addr}, sdr_addr);
			check_val($sformatf("sound %0d sdr_rd", i), s_rd, sdr_rd);
			check_val($sformatf("sound %0d sdr_word", i), 0, sdr_word);
		end

		// ========================================
		// Region map table
		// ========================================
		for (i = 0; i < N_ROWS; i++) begin
			ofs = 23'($urandom);
			if (tab_region[i] == 4)
				exp_byte = {5'b00000, ofs};
			else
				exp_byte = {tab_prefix[i], ofs[20:0]};
			@(posedge clk_sys);
			game_addr <= ofs;
			game_wdata <= $urandom;
			ddr_rdata <= $urandom;
			game_be <= tab_be[i];
			game_rd <= tab_rd[i];
			ddr_busy <= tab_busy[i];
			sel_ram <= (tab_region[i] == 1);
			sel_nvram <= (tab_region[i] == 2);
			sel_spr <= (tab_region[i] == 3);
			sel_rom <= (tab_region[i] == 4);
			@(negedge clk_sys);
			if (tab_region[i] != 0) begin
				check_val($sformatf("row %0d ddr_addr", i), exp_byte[27:1], ddr_addr);
				check_val($sformatf("row %0d ddr_cache", i), exp_byte[24:23], ddr_cache);
			end
			check_val($sformatf("row %0d ddr_we", i), tab_we[i], ddr_we);
			check_val($sformatf("row %0d ddr_rd", i), tab_exp_rd[i], ddr_rd);
			check_val($sformatf("row %0d game_ready", i), tab_ready[i], game_ready);
			check_val($sformatf("row %0d ddr_din", i), game_wdata, ddr_din);
			check_val($sformatf("row %0d game_rdata", i), ddr_rdata, game_rdata);
		end

		$display("Summary: %0d checks, %0d errors, %0d timeouts", n_checks, n_errors,
			n_timeouts);
		if (n_errors == 0 && n_timeouts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/bt_pkg.sv
hw/fractional_ce.sv
hw/clock_enables.sv
hw/rom_loader.sv
hw/game_memory_map.sv
hw/bt_core_support.sv
test/tb_bt_core_support.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core-support testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module tb_bt_core_support || { echo "build failed"; exit 1; }

./obj_dir/Vtb_bt_core_support > sim.log 2>&1
cat sim.log

# The log decides the result
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation gave no result"; exit 1; }
exit 0
